// File: sim/hsk_relay_vectors.txt
# Columns: op arg_a arg_b, both args in hex
# SEND and EXPECT take first byte and count, SEND_BADSTOP a byte, GLITCH sixteenths of a bit
# HOLD level, FLAGS overflow frame_err, WAIT quiet bit times, CLEAR no args
# EXPECT goes ahead of the SEND that makes its frame
# After reset
FLAGS 0 0
WAIT c 0
# Relay in order
EXPECT a5 1
EXPECT 01 1
EXPECT 80 1
EXPECT 3c 1
SEND a5 1
SEND 01 1
SEND 80 1
SEND 3c 1
WAIT c 0
# Glitch rejection
GLITCH 3 0
WAIT c 0
FLAGS 0 0
EXPECT 69 1
SEND 69 1
WAIT c 0
# Framing error
SEND_BADSTOP 5a 0
FLAGS 0 1
EXPECT c3 1
SEND c3 1
WAIT c 0
# Hold and overflow
HOLD 1 0
EXPECT 10 10
SEND 10 14
FLAGS 1 1
HOLD 0 0
WAIT c 0
# Status clear
CLEAR 0 0
FLAGS 0 0
EXPECT 96 2
SEND 96 2
WAIT c 0
FLAGS 0 0

// File: sim.f
+incdir+src
src/turf_serial_pkg.sv
src/baud_tick_gen.sv
src/uart_rx_16x.sv
src/byte_fifo.sv
src/uart_tx_16x.sv
src/hsk_serial_relay.sv
sim/tb_clk_gen.sv
sim/tb_hsk_serial_relay.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the relay testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -f sim.f \
    --top-module tb_hsk_serial_relay -o tb_hsk_serial_relay > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/tb_hsk_serial_relay > sim.log 2>&1
cat sim.log

grep -q "^Simulation finished: PASS$" sim.log \
    && { echo "Run passed"; exit 0; } \
    || { echo "Run failed"; exit 1; }

// File: sim/tb_hsk_serial_relay.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module tb_hsk_serial_relay;

    localparam int    CLK_PERIOD = 100;
    // Nominal bit time on the testbench side, DUT runs at 199.8 clocks
    localparam int    BIT_CLKS   = 200;
    localparam string VEC_FILE   = "sim/hsk_relay_vectors.txt";

    typedef enum logic [2:0] {
        OP_SEND,
        OP_SEND_BADSTOP,
        OP_GLITCH,
        OP_HOLD,
        OP_CLEAR,
        OP_EXPECT,
        OP_FLAGS,
        OP_WAIT
    } op_e;

    logic ps_clk;
    logic rst_n;
    logic serial_rx;
    logic serial_tx;
    logic tx_hold;
    logic status_clr;
    logic overflow;
    logic frame_err;

    // Vector table and bytes still due on the output line
    op_e        vec_op [$];
    logic [7:0] vec_a  [$];
    logic [7:0] vec_b  [$];
    logic [7:0] exp_q  [$];
    logic       vec_ready = 1'b0;
    longint     wd_limit;

    tb_clk_gen #(
        .HALF_PERIOD  (CLK_PERIOD / 2),
        .RESET_CYCLES (8)
    ) tb_clk_gen_inst (
        .ps_clk  (ps_clk),
        .rst_n_o (rst_n)
    );

    hsk_serial_relay hsk_serial_relay_inst (
        .ps_clk       (ps_clk),
        .rst_n_i      (rst_n),
        .serial_rx_i  (serial_rx),
        .serial_tx_o  (serial_tx),
        .tx_hold_i    (tx_hold),
        .status_clr_i (status_clr),
        .overflow_o   (overflow),
        .frame_err_o  (frame_err)
    );

    ////////////////////////////////////////////////////////////
    // Checking and failure
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("Simulation finished: FAIL");
            $fatal(1, "Value check failed");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "Run aborted");
    endtask

    ////////////////////////////////////////////////////////////
    // Vector file
    ////////////////////////////////////////////////////////////

    task automatic load_vectors();
        int               fd;
        int               n;
        int               weight;
        logic [8*16-1:0]  tok;
        logic [8*128-1:0] rest;
        logic [7:0]       a;
        logic [7:0]       b;
        op_e              op;
        weight = 0;
        op     = OP_WAIT;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            abort_run("Cannot open the vector file sim/hsk_relay_vectors.txt");
        end
        while (!$feof(fd)) begin
            tok = '0;
            n = $fscanf(fd, "%s", tok);
            if (n == 1) begin
                if (tok == 128'("#")) begin
                    // Rest of a comment line
                    n = $fgets(rest, fd);
                end else begin
                    case (tok)
                        128'("SEND"):         op = OP_SEND;
                        128'("SEND_BADSTOP"): op = OP_SEND_BADSTOP;
                        128'("GLITCH"):       op = OP_GLITCH;
                        128'("HOLD"):         op = OP_HOLD;
                        128'("CLEAR"):        op = OP_CLEAR;
                        128'("EXPECT"):       op = OP_EXPECT;
                        128'("FLAGS"):        op = OP_FLAGS;
                        128'("WAIT"):         op = OP_WAIT;
                        default: abort_run("Unknown operation in the vector file");
                    endcase
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2) begin
                        abort_run("Vector line is missing its two arguments");
                    end
                    vec_op.push_back(op);
                    vec_a.push_back(a);
                    vec_b.push_back(b);
                    // Runs of bytes count once per byte
                    weight += ((op == OP_SEND) || (op == OP_EXPECT)) ? int'(b) : 1;
                end
            end
        end
        $fclose(fd);
        // 12 bit times per unit of work plus slack for the final drain
        wd_limit  = longint'(weight * 12 + 100) * longint'(BIT_CLKS * CLK_PERIOD);
        vec_ready = 1'b1;
    endtask

    ////////////////////////////////////////////////////////////
    // Serial driver
    ////////////////////////////////////////////////////////////

    // Starts and ends 1 ns after a rising edge
    task automatic drive_line(input logic level, input int clocks);
        serial_rx = level;
        repeat (clocks) @(posedge ps_clk);
        #1;
    endtask

    // Start bit, 8 data bits LSB first, stop bit
    task automatic send_frame(input logic [7:0] data, input logic stop_bit);
        drive_line(1'b0, BIT_CLKS);
        for (int i = 0; i < 8; i++) begin
            drive_line(data[i], BIT_CLKS);
        end
        drive_line(stop_bit, BIT_CLKS);
        // Back to marking so the next start bit has an edge
        if (!stop_bit) begin
            drive_line(1'b1, BIT_CLKS);
        end
    endtask

    task automatic run_op(input op_e op, input logic [7:0] a, input logic [7:0] b);
        case (op)
            OP_SEND: begin
                for (int i = 0; i < int'(b); i++) begin
                    send_frame(a + 8'(i), 1'b1);
                end
            end
            OP_SEND_BADSTOP: begin
                send_frame(a, 1'b0);
            end
            OP_GLITCH: begin
                // Low time given in sixteenths of a bit
                drive_line(1'b0, int'(a) * BIT_CLKS / `TURF_OVERSAMPLE);
                drive_line(1'b1, BIT_CLKS);
            end
            OP_HOLD: begin
                tx_hold = a[0];
                @(posedge ps_clk);
                #1;
            end
            OP_CLEAR: begin
                status_clr = 1'b1;
                @(posedge ps_clk);
                #1;
                status_clr = 1'b0;
            end
            OP_EXPECT: begin
                for (int i = 0; i < int'(b); i++) begin
                    exp_q.push_back(a + 8'(i));
                end
            end
            OP_FLAGS: begin
                check_value("overflow_o", 32'(overflow), 32'(a[0]));
                check_value("frame_err_o", 32'(frame_err), 32'(b[0]));
            end
            OP_WAIT: begin
                // Drain due frames, then watch a quiet line
                do begin
                    @(posedge ps_clk);
                end while (exp_q.size() != 0);
                #1;
                drive_line(1'b1, int'(a) * BIT_CLKS);
            end
            default: begin
                abort_run("Bad operation code in the vector table");
            end
        endcase
    endtask

    ////////////////////////////////////////////////////////////
    // Output monitor
    ////////////////////////////////////////////////////////////

    // Samples on the falling clock, away from DUT updates
    initial begin
        logic [7:0] got;
        logic [7:0] exp_byte;
        wait (rst_n);
        forever begin
            @(negedge serial_tx);
            if (exp_q.size() == 0) begin
                abort_run("Frame started on serial_tx_o with no byte expected");
            end
            repeat (BIT_CLKS / 2) @(negedge ps_clk);
            check_value("serial_tx_o start bit", 32'(serial_tx), 32'd0);
            for (int i = 0; i < 8; i++) begin
                repeat (BIT_CLKS) @(negedge ps_clk);
                got[i] = serial_tx;
            end
            repeat (BIT_CLKS) @(negedge ps_clk);
            check_value("serial_tx_o stop bit", 32'(serial_tx), 32'd1);
            exp_byte = exp_q.pop_front();
            check_value("serial_tx_o byte", 32'(got), 32'(exp_byte));
        end
    end

    // Watchdog, armed once the vector count is known
    initial begin
        wait (vec_ready);
        #(wd_limit);
        $display("Run timed out after %0d ns without finishing the vectors", wd_limit);
        $display("Simulation finished: FAIL");
        $fatal(1, "Watchdog expired");
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        serial_rx  = 1'b1;
        tx_hold    = 1'b0;
        status_clr = 1'b0;
        load_vectors();
        wait (rst_n);
        @(posedge ps_clk);
        #1;
        // Idle line and clear flags out of reset
        check_value("serial_tx_o", 32'(serial_tx), 32'd1);
        check_value("overflow_o", 32'(overflow), 32'd0);
        check_value("frame_err_o", 32'(frame_err), 32'd0);
        for (int i = 0; i < vec_op.size(); i++) begin
            run_op(vec_op[i], vec_a[i], vec_b[i]);
        end
        if (exp_q.size() != 0) begin
            $display("%0d expected bytes never appeared on serial_tx_o", exp_q.size());
            $display("Simulation finished: FAIL");
            $fatal(1, "Bytes missing");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_PERIOD  = 50,
    parameter int RESET_CYCLES = 8
) (
    output logic ps_clk,
    output logic rst_n_o
);

    // Free-running clock, low at time zero
    initial begin
        ps_clk = 1'b0;
        forever #(HALF_PERIOD) ps_clk = ~ps_clk;
    end

    // Reset drops 1 ns after an edge, same as the other inputs
    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge ps_clk);
        #1;
        rst_n_o = 1'b1;
    end

endmodule

// File: src/hsk_serial_relay.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module hsk_serial_relay (
    input  logic ps_clk,
    input  logic rst_n_i,
    input  logic serial_rx_i,
    output logic serial_tx_o,
    input  logic tx_hold_i,
    input  logic status_clr_i,
    output logic overflow_o,
    output logic frame_err_o
);

    ////////////////////////////////////////////////////////////
    // Internal nets
    ////////////////////////////////////////////////////////////

    // Shared 16x tick so both sides run at one rate
    logic                   tick_16x;
    // Receiver to FIFO
    turf_serial_pkg::byte_t rx_byte;
    logic                   rx_strobe;
    logic                   rx_frame_err;
    // FIFO to transmitter
    turf_serial_pkg::byte_t rd_data;
    logic                   fifo_empty;
    logic                   rd_pop;

    baud_tick_gen baud_tick_gen_inst (
        .ps_clk  (ps_clk),
        .rst_n_i (rst_n_i),
        .tick_o  (tick_16x)
    );

    uart_rx_16x uart_rx_16x_inst (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .tick_i      (tick_16x),
        .serial_rx_i (serial_rx_i),
        .byte_o      (rx_byte),
        .strobe_o    (rx_strobe),
        .frame_err_o (rx_frame_err)
    );

    // Status clear also drops the FIFO's overflow flag
    byte_fifo byte_fifo_inst (
        .ps_clk     (ps_clk),
        .rst_n_i    (rst_n_i),
        .wr_i       (rx_strobe),
        .wr_data_i  (rx_byte),
        .rd_i       (rd_pop),
        .rd_data_o  (rd_data),
        .empty_o    (fifo_empty),
        .clr_i      (status_clr_i),
        .overflow_o (overflow_o)
    );

    uart_tx_16x uart_tx_16x_inst (
        .ps_clk      (ps_clk),
        .rst_n_i     (rst_n_i),
        .tick_i      (tick_16x),
        .hold_i      (tx_hold_i),
        .data_i      (rd_data),
        .empty_i     (fifo_empty),
        .pop_o       (rd_pop),
        .serial_tx_o (serial_tx_o)
    );

    ////////////////////////////////////////////////////////////
    // Sticky framing error
    ////////////////////////////////////////////////////////////

    // Error pulse in the clear cycle wins
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            frame_err_o <= 1'b0;
        end else if (rx_frame_err) begin
            frame_err_o <= 1'b1;
        end else if (status_clr_i) begin
            frame_err_o <= 1'b0;
        end
    end

endmodule

// File: src/uart_tx_16x.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module uart_tx_16x (
    input  logic                   ps_clk,
    input  logic                   rst_n_i,
    input  logic                   tick_i,
    input  logic                   hold_i,
    input  turf_serial_pkg::byte_t data_i,
    input  logic                   empty_i,
    output logic                   pop_o,
    output logic                   serial_tx_o
);

    localparam int TW = $clog2(`TURF_OVERSAMPLE);

    // Last tick of a full bit
    localparam logic [TW-1:0] BIT_LAST = TW'(`TURF_OVERSAMPLE - 1);

    ////////////////////////////////////////////////////////////
    // Transmit FSM
    ////////////////////////////////////////////////////////////

    turf_serial_pkg::tx_state_e state_q;
    logic [TW-1:0]              tick_cnt;
    logic [2:0]                 bit_cnt;
    turf_serial_pkg::byte_t     shift_q;
    logic                       start_frame;
    logic                       bit_done;

    // Hold only blocks new frames
    assign start_frame = (state_q == turf_serial_pkg::TX_IDLE) && tick_i &&
                         !empty_i && !hold_i;
    // Head byte leaves the FIFO as the frame starts
    assign pop_o = start_frame;

    assign bit_done = tick_i && (tick_cnt == BIT_LAST);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state_q     <= turf_serial_pkg::TX_IDLE;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            serial_tx_o <= 1'b1;
        end else begin
            case (state_q)
                turf_serial_pkg::TX_IDLE: begin
                    if (start_frame) begin
                        // Start bit goes out now
                        serial_tx_o <= 1'b0;
                        tick_cnt    <= '0;
                        state_q     <= turf_serial_pkg::TX_START;
                    end
                end
                turf_serial_pkg::TX_START: begin
                    if (bit_done) begin
                        serial_tx_o <= shift_q[0];
                        tick_cnt    <= '0;
                        bit_cnt     <= '0;
                        state_q     <= turf_serial_pkg::TX_DATA;
                    end else if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                turf_serial_pkg::TX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            // Stop bit
                            serial_tx_o <= 1'b1;
                            state_q     <= turf_serial_pkg::TX_STOP;
                        end else begin
                            serial_tx_o <= shift_q[0];
                        end
                    end else if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                turf_serial_pkg::TX_STOP: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        state_q  <= turf_serial_pkg::TX_IDLE;
                    end else if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    serial_tx_o <= 1'b1;
                    state_q     <= turf_serial_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Byte latched at frame start
    // Shifted right at each bit edge so bit 0 is always the next one out
    always_ff @(posedge ps_clk) begin
        if (start_frame) begin
            shift_q <= data_i;
        end else if (bit_done && ((state_q == turf_serial_pkg::TX_START) ||
                                  (state_q == turf_serial_pkg::TX_DATA))) begin
            shift_q <= {1'b1, shift_q[7:1]};
        end
    end

    // Idle line is always marking
    a_tx_idle_high: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        (state_q == turf_serial_pkg::TX_IDLE) |-> serial_tx_o);

endmodule

// File: src/byte_fifo.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module byte_fifo (
    input  logic                   ps_clk,
    input  logic                   rst_n_i,
    input  logic                   wr_i,
    input  turf_serial_pkg::byte_t wr_data_i,
    input  logic                   rd_i,
    output turf_serial_pkg::byte_t rd_data_o,
    output logic                   empty_o,
    input  logic                   clr_i,
    output logic                   overflow_o
);

    localparam int AW = `TURF_FIFO_AW;

    ////////////////////////////////////////////////////////////
    // Storage and pointers
    ////////////////////////////////////////////////////////////

    turf_serial_pkg::byte_t mem [`TURF_FIFO_DEPTH];

    // Extra top bit tells full from empty
    logic [AW:0] wr_ptr;
    logic [AW:0] rd_ptr;
    logic        full;
    logic        wr_ok;

    assign empty_o = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[AW] != rd_ptr[AW]) &&
                     (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

    // Writes into a full buffer are lost
    assign wr_ok = wr_i && !full;

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wr_ok) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            // Transmitter only pops while not empty
            if (rd_i) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    always_ff @(posedge ps_clk) begin
        if (wr_ok) begin
            mem[wr_ptr[AW-1:0]] <= wr_data_i;
        end
    end

    // Head entry, valid while not empty
    assign rd_data_o = mem[rd_ptr[AW-1:0]];

    ////////////////////////////////////////////////////////////
    // Sticky overflow
    ////////////////////////////////////////////////////////////

    // A new drop in the clear cycle still shows
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            overflow_o <= 1'b0;
        end else if (wr_i && full) begin
            overflow_o <= 1'b1;
        end else if (clr_i) begin
            overflow_o <= 1'b0;
        end
    end

    // No pop from an empty buffer
    a_fifo_no_underflow: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        !(rd_i && empty_o));

endmodule

// File: src/uart_rx_16x.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module uart_rx_16x (
    input  logic                   ps_clk,
    input  logic                   rst_n_i,
    input  logic                   tick_i,
    input  logic                   serial_rx_i,
    output turf_serial_pkg::byte_t byte_o,
    output logic                   strobe_o,
    output logic                   frame_err_o
);

    localparam int TW = $clog2(`TURF_OVERSAMPLE);

    // Last tick of the half bit after the start edge
    localparam logic [TW-1:0] MID_LAST = TW'(`TURF_MID_SAMPLE - 1);
    // Last tick of a full bit
    localparam logic [TW-1:0] BIT_LAST = TW'(`TURF_OVERSAMPLE - 1);

    ////////////////////////////////////////////////////////////
    // Input synchronizer and edge detect
    ////////////////////////////////////////////////////////////

    logic rx_meta;
    logic rx_sync;
    logic rx_prev;
    logic start_edge;

    // Idle line is high, so reset to 1 to avoid a false start
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= serial_rx_i;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    assign start_edge = rx_prev & ~rx_sync;

    ////////////////////////////////////////////////////////////
    // Receive FSM
    ////////////////////////////////////////////////////////////

    turf_serial_pkg::rx_state_e state_q;
    logic [TW-1:0]              tick_cnt;
    logic [2:0]                 bit_cnt;
    turf_serial_pkg::byte_t     shift_q;
    logic                       bit_done;

    // Sample point of a data or stop bit
    assign bit_done = tick_i && (tick_cnt == BIT_LAST);

    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            state_q     <= turf_serial_pkg::RX_IDLE;
            tick_cnt    <= '0;
            bit_cnt     <= '0;
            strobe_o    <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            // Both outputs are single-cycle pulses
            strobe_o    <= 1'b0;
            frame_err_o <= 1'b0;
            case (state_q)
                turf_serial_pkg::RX_IDLE: begin
                    if (start_edge) begin
                        state_q  <= turf_serial_pkg::RX_START;
                        tick_cnt <= '0;
                    end
                end
                turf_serial_pkg::RX_START: begin
                    if (tick_i) begin
                        if (tick_cnt == MID_LAST) begin
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            // High at mid start means a glitch
                            state_q  <= rx_sync ? turf_serial_pkg::RX_IDLE
                                                : turf_serial_pkg::RX_DATA;
                        end else begin
                            tick_cnt <= tick_cnt + 1'b1;
                        end
                    end
                end
                turf_serial_pkg::RX_DATA: begin
                    if (bit_done) begin
                        tick_cnt <= '0;
                        bit_cnt  <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state_q <= turf_serial_pkg::RX_STOP;
                        end
                    end else if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                turf_serial_pkg::RX_STOP: begin
                    if (bit_done) begin
                        tick_cnt    <= '0;
                        // Good stop bit writes the byte, a low one flags it
                        strobe_o    <= rx_sync;
                        frame_err_o <= ~rx_sync;
                        state_q     <= turf_serial_pkg::RX_IDLE;
                    end else if (tick_i) begin
                        tick_cnt <= tick_cnt + 1'b1;
                    end
                end
                default: begin
                    state_q <= turf_serial_pkg::RX_IDLE;
                end
            endcase
        end
    end

    // Data shifts in LSB first
    // Byte is complete well before the stop-bit sample
    always_ff @(posedge ps_clk) begin
        if ((state_q == turf_serial_pkg::RX_DATA) && bit_done) begin
            shift_q <= {rx_sync, shift_q[7:1]};
        end
    end

    assign byte_o = shift_q;

    // A frame ends in a byte or an error, never both
    a_rx_one_result: assert property (@(posedge ps_clk) disable iff (!rst_n_i)
        !(strobe_o && frame_err_o));

endmodule

// File: src/baud_tick_gen.sv
`timescale 1ns/1ps
`include "turf_serial_params.svh"

module baud_tick_gen (
    input  logic ps_clk,
    input  logic rst_n_i,
    output logic tick_o
);

    ////////////////////////////////////////////////////////////
    // Fractional phase accumulator
    ////////////////////////////////////////////////////////////

    localparam int ACC_W = `TURF_BAUD_ACC_W;

    // Increment, zero-extended to make room for the carry
    localparam logic [ACC_W:0] BAUD_ADD = {1'b0, `TURF_BAUD_ADD};

    // Top bit holds the carry of the last add
    logic [ACC_W:0] acc_q;

    // Drop the old carry and add again every clock
    always_ff @(posedge ps_clk) begin
        if (!rst_n_i) begin
            acc_q <= '0;
        end else begin
            acc_q <= {1'b0, acc_q[ACC_W-1:0]} + BAUD_ADD;
        end
    end

    // Carry is registered already
    // Increment is far below 2**ACC_W so it lasts one clock only
    assign tick_o = acc_q[ACC_W];

endmodule

// File: src/turf_serial_pkg.sv
package turf_serial_pkg;

    ////////////////////////////////////////////////////////////
    // Serial relay types
    ////////////////////////////////////////////////////////////

    // One byte on the wire
    typedef logic [7:0] byte_t;

    // Receiver FSM
    // Falling edge moves IDLE to START, mid-start check moves on to DATA
    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    // Transmitter FSM
    // One state per part of the frame
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } tx_state_e;

endpackage

// File: src/turf_serial_params.svh
`ifndef TURF_SERIAL_PARAMS_SVH
`define TURF_SERIAL_PARAMS_SVH

////////////////////////////////////////////////////////////
// Baud timing
////////////////////////////////////////////////////////////

// Fraction width of the phase accumulator
`define TURF_BAUD_ACC_W 10
// 82 in 1024 gives a 16x tick every 12.49 clocks
`define TURF_BAUD_ADD 10'd82

////////////////////////////////////////////////////////////
// Buffer and sampling
////////////////////////////////////////////////////////////

// Byte FIFO entries and address bits
`define TURF_FIFO_DEPTH 16
`define TURF_FIFO_AW 4

// Ticks per bit
`define TURF_OVERSAMPLE 16
// Tick within a bit where the line is sampled
`define TURF_MID_SAMPLE 8

`endif
